// File: verilog.f
purgePkg.sv
readoutSequencer.sv
duplicateTagger.sv
trackMerger.sv
purgeDuplicate.sv
purgeDuplicate_chk.sv
tb_purgeDuplicate.sv

// File: Makefile
SIM := obj_dir/Vtb_purgeDuplicate

all: run

$(SIM): verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_purgeDuplicate -f verilog.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: tb_purgeDuplicate.sv
`timescale 1ns/1ps
`default_nettype none

module tb_purgeDuplicate
    import purgePkg::*;
();

    localparam int NUM_SEEDS    = DEF_NUM_SEEDS;
    localparam int TPS          = DEF_TRACKS_PER_SEED;
    localparam int NUM_TRACKS   = NUM_SEEDS * TPS;
    localparam int STUB_ID_W    = DEF_STUB_ID_W;
    localparam int STUB_W       = DEF_STUBS_PER_TRACK * STUB_ID_W;
    localparam int TRACK_W      = DEF_TRACK_W;
    localparam int COUNT_W      = $clog2(TPS + 1);
    localparam int ID_W         = $clog2(NUM_TRACKS);
    localparam int NUM_EVENTS   = 25;
    localparam int EVENT_CYCLES = 32;   // Start, 13 tag cycles, full drain, done, gap
    localparam int MAX_CYCLES   = 10 * NUM_EVENTS * EVENT_CYCLES;

    logic               clk = 1'b0;
    logic               rst_pipe;
    logic               start;
    logic [COUNT_W-1:0] trackCount [NUM_SEEDS];
    logic [STUB_W-1:0]  stubIndex  [NUM_TRACKS];
    logic [TRACK_W-1:0] trackIn;
    logic [ID_W-1:0]    readAddr;
    logic               readEnable;
    logic               outStrobe;
    logic [ID_W-1:0]    outId;
    logic [TRACK_W-1:0] outTrack;
    logic               outGood;
    logic               done;

    int                 expId [$];      // Expected output stream, in order
    logic [TRACK_W-1:0] expTrack [$];
    logic               expGood [$];
    int                 outIdx, rdIdx, tests, seedInit;
    int                 errors = 0;
    int                 checks = 0;
    int                 cycles = 0;
    logic               doneSeen;
    logic               strobeBefore = 1'b0;   // outStrobe one cycle earlier
    logic               memRead;
    logic [ID_W-1:0]    memAddr;

    purgeDuplicate u_dut (
        .clk(clk), .rst_pipe(rst_pipe), .start(start), .trackCount(trackCount),
        .stubIndex(stubIndex), .trackIn(trackIn), .readAddr(readAddr),
        .readEnable(readEnable), .outStrobe(outStrobe), .outId(outId),
        .outTrack(outTrack), .outGood(outGood), .done(done)
    );

    always #2 clk = ~clk;

    // Track memory with one cycle of read latency
    always @(posedge clk) begin
        memRead = readEnable;
        memAddr = readAddr;
        #1;
        if (memRead) trackIn = memWord(memAddr);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("run stopped after %0d cycles, done never arrived", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [TRACK_W-1:0] memWord(input logic [ID_W-1:0] addr);
        logic [31:0] a;
        a = 32'(addr) + 32'd1;
        return (a * 32'h9e3779b1) ^ {a[15:0], a[15:0]} ^ 32'h5a5a0000;
    endfunction

    function automatic bit isPresent(input int id);
        return int'(trackCount[id / TPS]) > id % TPS;
    endfunction

    // Equal fields, a zero field never counts
    function automatic int sharedStubs(input int p, input int q);
        int                   n;
        logic [STUB_ID_W-1:0] a, b;
        n = 0;
        for (int k = 0; k < DEF_STUBS_PER_TRACK; k++) begin
            a = stubIndex[p][k*STUB_ID_W +: STUB_ID_W];
            b = stubIndex[q][k*STUB_ID_W +: STUB_ID_W];
            if (a != '0 && a == b) n++;
        end
        return n;
    endfunction

    function automatic void computeExpected();
        bit dup [NUM_TRACKS];
        expId.delete();
        expTrack.delete();
        expGood.delete();
        foreach (dup[i]) dup[i] = 1'b0;
        for (int p = 0; p < NUM_TRACKS; p++) begin
            if (isPresent(p) && !dup[p]) begin   // Tagged primaries tag nothing
                for (int q = p + 1; q < NUM_TRACKS; q++) begin
                    if (isPresent(q) && sharedStubs(p, q) >= DEF_MATCH_THRESHOLD) dup[q] = 1'b1;
                end
            end
        end
        for (int id = 0; id < NUM_TRACKS; id++) begin
            if (isPresent(id)) begin
                expId.push_back(id);
                expTrack.push_back(memWord(ID_W'(id)));
                expGood.push_back(!dup[id]);
            end
        end
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // Read addresses and output stream against the expected list
    always @(negedge clk) begin
        if (!rst_pipe) begin
            if (readEnable) begin
                if (rdIdx < expId.size()) begin
                    checkValue("readAddr", 32'(readAddr), 32'(expId[rdIdx]));
                end else begin
                    errors++;
                    $display("unexpected read of address %0d at %0t ns", readAddr, $time);
                end
                rdIdx++;
            end
            if (outStrobe) begin
                if (outIdx < expId.size()) begin
                    checkValue("outId", 32'(outId), 32'(expId[outIdx]));
                    checkValue("outTrack", outTrack, expTrack[outIdx]);
                    checkValue("outGood", 32'(outGood), 32'(expGood[outIdx]));
                end else begin
                    errors++;
                    $display("extra output track %0d at %0t ns", outId, $time);
                end
                outIdx++;
            end
            if (done) begin
                doneSeen = 1'b1;
                // Done belongs right after the last strobe
                if (outIdx != expId.size() || (expId.size() > 0 && !strobeBefore)) begin
                    errors++;
                    $display("done at %0t ns did not follow the last output track", $time);
                end
            end
            strobeBefore = outStrobe;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic runEvent();
        computeExpected();
        outIdx   = 0;
        rdIdx    = 0;
        doneSeen = 1'b0;
        start    = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        while (!doneSeen) @(posedge clk);
        #1;
        if (outIdx != expId.size() || rdIdx != expId.size()) begin
            errors++;
            $display("only %0d outputs and %0d reads for %0d present tracks",
                     outIdx, rdIdx, expId.size());
        end
    endtask

    task automatic clearInputs();
        foreach (trackCount[s]) trackCount[s] = '0;
        foreach (stubIndex[j]) stubIndex[j] = '0;
    endtask

    task automatic setStubs(input int id, input int f0, input int f1, input int f2,
                            input int f3);
        stubIndex[id] = {STUB_ID_W'(f3), STUB_ID_W'(f2), STUB_ID_W'(f1), STUB_ID_W'(f0)};
    endtask

    // All 48 fields differ and none is zero
    task automatic fillDistinct(input int offset);
        for (int j = 0; j < NUM_TRACKS; j++) begin
            for (int k = 0; k < DEF_STUBS_PER_TRACK; k++) begin
                stubIndex[j][k*STUB_ID_W +: STUB_ID_W] = STUB_ID_W'((j * 4 + k + offset) % 63 + 1);
            end
        end
    endtask

    task automatic endTest(input string name, input int errBefore);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errBefore);
    endtask

    initial begin
        int errBefore;
        seedInit = $urandom(32'he24cb884);
        tests    = 0;
        rst_pipe = 1'b1;
        start    = 1'b0;
        trackIn  = '0;
        clearInputs();
        repeat (5) @(posedge clk);
        #1 rst_pipe = 1'b0;
        @(posedge clk);
        #1;

        errBefore = errors;
        runEvent();
        endTest("no tracks", errBefore);

        errBefore = errors;
        fillDistinct(int'($urandom_range(0, 62)));
        trackCount = '{3'd4, 3'd4, 3'd4};
        runEvent();
        trackCount = '{3'd2, 3'd4, 3'd1};
        runEvent();
        endTest("distinct tracks", errBefore);

        // Later track of each pair gets flagged
        errBefore = errors;
        fillDistinct(0);
        trackCount = '{3'd4, 3'd3, 3'd2};
        setStubs(1, 1, 2, 3, 4);       // Four shared with 0, same sector
        setStubs(6, 9, 10, 11, 60);    // Three shared with 2
        setStubs(8, 21, 22, 23, 24);   // Four shared with 5
        setStubs(9, 61, 18, 19, 20);   // Three shared with 4
        runEvent();
        endTest("planted duplicates", errBefore);

        errBefore = errors;
        clearInputs();
        trackCount = '{3'd3, 3'd3, 3'd3};
        setStubs(0, 10, 11, 12, 13);   // A
        setStubs(1, 10, 11, 12, 20);   // B matches A
        setStubs(4, 10, 11, 21, 20);   // C matches only B
        setStubs(5, 0, 0, 0, 30);
        setStubs(8, 0, 0, 0, 30);
        setStubs(6, 31, 32, 33, 0);
        setStubs(9, 31, 32, 0, 0);
        setStubs(10, 31, 32, 33, 0);
        runEvent();
        endTest("zero fields and chains", errBefore);

        errBefore = errors;
        for (int e = 0; e < 20; e++) begin
            for (int s = 0; s < NUM_SEEDS; s++) trackCount[s] = COUNT_W'($urandom_range(0, TPS));
            if (e % 2 == 0) trackCount[1] = '0;   // Empty middle sector
            for (int j = 0; j < NUM_TRACKS; j++) begin
                for (int k = 0; k < DEF_STUBS_PER_TRACK; k++) begin
                    // Small alphabet gives zeros and plenty of matches
                    stubIndex[j][k*STUB_ID_W +: STUB_ID_W] = STUB_ID_W'($urandom_range(0, 7));
                end
            end
            runEvent();
        end
        endTest("empty-sector skipping", errBefore);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: purgeDuplicate_chk.sv
`timescale 1ns/1ps
`default_nettype none

module purgeDuplicate_chk #(
    parameter int ID_W = 4
) (
    input logic            clk,
    input logic            rst_pipe,
    input logic            readEnable,
    input logic            outStrobe,
    input logic [ID_W-1:0] outId,
    input logic            done
);

    // Done follows the last strobe, never with it
    doneApart: assert property (@(posedge clk) disable iff (rst_pipe) !(done && outStrobe))
        else $error("done and outStrobe high in the same cycle");

    resetQuiet: assert property (@(posedge clk) rst_pipe && $past(rst_pipe) |-> !readEnable)
        else $error("readEnable high during reset");

    // Strobes of one event are back to back
    idAscend: assert property (@(posedge clk) disable iff (rst_pipe)
        outStrobe && $past(outStrobe) |-> outId > $past(outId))
        else $error("outId did not ascend within an event");

endmodule

bind purgeDuplicate purgeDuplicate_chk #(.ID_W(ID_W)) u_chk (
    .clk(clk), .rst_pipe(rst_pipe), .readEnable(readEnable),
    .outStrobe(outStrobe), .outId(outId), .done(done)
);

`default_nettype wire

// File: purgeDuplicate.sv
`timescale 1ns/1ps
`default_nettype none

module purgeDuplicate
    import purgePkg::*;
#(
    parameter int NUM_SEEDS       = DEF_NUM_SEEDS,
    parameter int TRACKS_PER_SEED = DEF_TRACKS_PER_SEED,
    parameter int STUBS_PER_TRACK = DEF_STUBS_PER_TRACK,
    parameter int STUB_ID_W       = DEF_STUB_ID_W,
    parameter int TRACK_W         = DEF_TRACK_W,
    parameter int MATCH_THRESHOLD = DEF_MATCH_THRESHOLD,
    localparam int NUM_TRACKS = NUM_SEEDS * TRACKS_PER_SEED,
    localparam int ID_W       = (NUM_TRACKS > 1) ? $clog2(NUM_TRACKS) : 1,
    localparam int COUNT_W    = $clog2(TRACKS_PER_SEED + 1),
    localparam int STUB_W     = STUBS_PER_TRACK * STUB_ID_W
) (
    input  logic               clk,
    input  logic               rst_pipe,
    input  logic               start,
    input  logic [COUNT_W-1:0] trackCount [NUM_SEEDS],
    input  logic [STUB_W-1:0]  stubIndex  [NUM_TRACKS],
    input  logic [TRACK_W-1:0] trackIn,     // Track memory data, one cycle after read
    output logic [ID_W-1:0]    readAddr,
    output logic               readEnable,
    output logic               outStrobe,
    output logic [ID_W-1:0]    outId,
    output logic [TRACK_W-1:0] outTrack,
    output logic               outGood,
    output logic               done
);

    // Sequencer to merger
    logic               retStrobe;
    logic [ID_W-1:0]    retId;
    logic [TRACK_W-1:0] retTrack;
    logic               readsFinished;

    // Tagger to merger
    logic [NUM_TRACKS-1:0] dupFlags;
    logic                  tagDone;

    readoutSequencer #(
        .NUM_SEEDS(NUM_SEEDS), .TRACKS_PER_SEED(TRACKS_PER_SEED), .TRACK_W(TRACK_W)
    ) u_seq (
        .clk(clk), .rst_pipe(rst_pipe), .start(start), .trackCount(trackCount),
        .trackIn(trackIn), .readAddr(readAddr), .readEnable(readEnable),
        .retStrobe(retStrobe), .retId(retId), .retTrack(retTrack),
        .readsFinished(readsFinished)
    );

    duplicateTagger #(
        .NUM_SEEDS(NUM_SEEDS), .TRACKS_PER_SEED(TRACKS_PER_SEED),
        .STUBS_PER_TRACK(STUBS_PER_TRACK), .STUB_ID_W(STUB_ID_W),
        .MATCH_THRESHOLD(MATCH_THRESHOLD)
    ) u_tag (
        .clk(clk), .rst_pipe(rst_pipe), .start(start), .trackCount(trackCount),
        .stubIndex(stubIndex), .dupFlags(dupFlags), .tagDone(tagDone)
    );

    trackMerger #(
        .NUM_SEEDS(NUM_SEEDS), .TRACKS_PER_SEED(TRACKS_PER_SEED), .TRACK_W(TRACK_W)
    ) u_merge (
        .clk(clk), .rst_pipe(rst_pipe), .start(start), .trackCount(trackCount),
        .retStrobe(retStrobe), .retId(retId), .retTrack(retTrack),
        .readsFinished(readsFinished), .dupFlags(dupFlags), .tagDone(tagDone),
        .outStrobe(outStrobe), .outId(outId), .outTrack(outTrack),
        .outGood(outGood), .done(done)
    );

endmodule

`default_nettype wire

// File: trackMerger.sv
`timescale 1ns/1ps
`default_nettype none

module trackMerger
    import purgePkg::*;
#(
    parameter int NUM_SEEDS       = DEF_NUM_SEEDS,
    parameter int TRACKS_PER_SEED = DEF_TRACKS_PER_SEED,
    parameter int TRACK_W         = DEF_TRACK_W,
    localparam int NUM_TRACKS = NUM_SEEDS * TRACKS_PER_SEED,
    localparam int ID_W       = (NUM_TRACKS > 1) ? $clog2(NUM_TRACKS) : 1,
    localparam int COUNT_W    = $clog2(TRACKS_PER_SEED + 1)
) (
    input  logic                  clk,
    input  logic                  rst_pipe,
    input  logic                  start,
    input  logic [COUNT_W-1:0]    trackCount [NUM_SEEDS],
    input  logic                  retStrobe,
    input  logic [ID_W-1:0]       retId,
    input  logic [TRACK_W-1:0]    retTrack,
    input  logic                  readsFinished,
    input  logic [NUM_TRACKS-1:0] dupFlags,
    input  logic                  tagDone,
    output logic                  outStrobe,
    output logic [ID_W-1:0]       outId,
    output logic [TRACK_W-1:0]    outTrack,
    output logic                  outGood,
    output logic                  done
);

    mergeState_e        mergeState;
    logic [TRACK_W-1:0] trackBuf [NUM_TRACKS];   // Indexed by global id
    logic               seenReads, seenTag;
    logic [ID_W-1:0]    scanId;
    logic               scanValid;
    logic [ID_W-1:0]    firstId, nextId;
    logic               anyPresent, nextFound;

    // Lowest present id, and lowest present id above the scan pointer
    always_comb begin
        anyPresent = 1'b0;
        firstId    = '0;
        nextFound  = 1'b0;
        nextId     = '0;
        for (int j = NUM_TRACKS - 1; j >= 0; j--) begin
            if (COUNT_W'(j % TRACKS_PER_SEED) < trackCount[j / TRACKS_PER_SEED]) begin
                anyPresent = 1'b1;
                firstId    = ID_W'(j);
                if (j > int'(scanId)) begin
                    nextFound = 1'b1;
                    nextId    = ID_W'(j);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retStrobe) begin
            trackBuf[retId] <= retTrack;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_pipe) begin
            mergeState <= MERGE_IDLE;
            seenReads  <= 1'b0;
            seenTag    <= 1'b0;
            scanId     <= '0;
            scanValid  <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (mergeState)
                MERGE_IDLE: begin
                    if (start) begin
                        mergeState <= MERGE_FILL;
                        seenReads  <= 1'b0;
                        seenTag    <= 1'b0;
                    end
                end
                MERGE_FILL: begin
                    if (readsFinished) seenReads <= 1'b1;
                    if (tagDone)       seenTag   <= 1'b1;
                    if ((seenReads || readsFinished) && (seenTag || tagDone)) begin
                        mergeState <= MERGE_DRAIN;
                        scanId     <= firstId;
                        scanValid  <= anyPresent;   // Zero tracks drains nothing
                    end
                end
                MERGE_DRAIN: begin
                    if (scanValid && nextFound) begin
                        scanId <= nextId;
                    end else begin
                        scanValid  <= 1'b0;
                        mergeState <= MERGE_IDLE;
                        done       <= 1'b1;   // Cycle after the last strobe
                    end
                end
                default: mergeState <= MERGE_IDLE;
            endcase
        end
    end

    assign outStrobe = (mergeState == MERGE_DRAIN) && scanValid;
    assign outId     = scanId;
    assign outTrack  = trackBuf[scanId];
    assign outGood   = !dupFlags[scanId];

endmodule

`default_nettype wire

// File: duplicateTagger.sv
`timescale 1ns/1ps
`default_nettype none

module duplicateTagger
    import purgePkg::*;
#(
    parameter int NUM_SEEDS       = DEF_NUM_SEEDS,
    parameter int TRACKS_PER_SEED = DEF_TRACKS_PER_SEED,
    parameter int STUBS_PER_TRACK = DEF_STUBS_PER_TRACK,
    parameter int STUB_ID_W       = DEF_STUB_ID_W,
    parameter int MATCH_THRESHOLD = DEF_MATCH_THRESHOLD,
    localparam int NUM_TRACKS = NUM_SEEDS * TRACKS_PER_SEED,
    localparam int COUNT_W    = $clog2(TRACKS_PER_SEED + 1),
    localparam int STUB_W     = STUBS_PER_TRACK * STUB_ID_W
) (
    input  logic                  clk,
    input  logic                  rst_pipe,
    input  logic                  start,
    input  logic [COUNT_W-1:0]    trackCount [NUM_SEEDS],
    input  logic [STUB_W-1:0]     stubIndex  [NUM_TRACKS],
    output logic [NUM_TRACKS-1:0] dupFlags,
    output logic                  tagDone
);

    localparam int ID_W    = (NUM_TRACKS > 1) ? $clog2(NUM_TRACKS) : 1;
    localparam int MATCH_W = $clog2(STUBS_PER_TRACK + 1);

    tagState_e             tagState;
    logic [ID_W-1:0]       prim;        // Current primary, global id
    logic [STUB_W-1:0]     primStubs;
    logic [NUM_TRACKS-1:0] presentVec;
    logic [NUM_TRACKS-1:0] laterVec;
    logic [NUM_TRACKS-1:0] matchVec;
    logic [NUM_TRACKS-1:0] tagVec;
    logic                  primLive;    // Primary is present and still good

    assign primStubs = stubIndex[prim];

    ////////////////////////////////////////////////////////////////////////////
    // Primary against every track, all in parallel
    ////////////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < NUM_TRACKS; j++) begin : g_cmp
        localparam int SEED = j / TRACKS_PER_SEED;
        localparam int SLOT = j % TRACKS_PER_SEED;

        logic [MATCH_W-1:0] eqCount;

        always_comb begin
            eqCount = '0;
            for (int k = 0; k < STUBS_PER_TRACK; k++) begin
                // Empty field never counts
                if ((primStubs[k*STUB_ID_W +: STUB_ID_W] != '0) &&
                    (primStubs[k*STUB_ID_W +: STUB_ID_W] ==
                     stubIndex[j][k*STUB_ID_W +: STUB_ID_W])) begin
                    eqCount = eqCount + 1'b1;
                end
            end
        end

        assign presentVec[j] = COUNT_W'(SLOT) < trackCount[SEED];
        assign laterVec[j]   = ID_W'(j) > prim;
        assign matchVec[j]   = eqCount >= MATCH_THRESHOLD;
    end

    assign tagVec   = presentVec & laterVec & matchVec;
    assign primLive = presentVec[prim] && !dupFlags[prim];

    ////////////////////////////////////////////////////////////////////////////
    // Primary stepping
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_pipe) begin
            tagState <= TAG_IDLE;
            prim     <= '0;
        end else begin
            case (tagState)
                TAG_IDLE: begin
                    if (start) begin
                        tagState <= TAG_COMPARE;
                        prim     <= '0;
                    end
                end
                TAG_COMPARE: begin
                    if (prim == ID_W'(NUM_TRACKS - 1)) begin
                        tagState <= TAG_FINISHED;
                    end else begin
                        prim <= prim + 1'b1;
                    end
                end
                TAG_FINISHED: tagState <= TAG_IDLE;
                default:      tagState <= TAG_IDLE;
            endcase
        end
    end

    // Flags only grow during one event, a tagged primary tags nothing
    always_ff @(posedge clk) begin
        if (tagState == TAG_IDLE && start) begin
            dupFlags <= '0;
        end else if (tagState == TAG_COMPARE && primLive) begin
            dupFlags <= dupFlags | tagVec;
        end
    end

    assign tagDone = (tagState == TAG_FINISHED);

endmodule

`default_nettype wire

// File: readoutSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module readoutSequencer
    import purgePkg::*;
#(
    parameter int NUM_SEEDS       = DEF_NUM_SEEDS,
    parameter int TRACKS_PER_SEED = DEF_TRACKS_PER_SEED,
    parameter int TRACK_W         = DEF_TRACK_W,
    localparam int NUM_TRACKS = NUM_SEEDS * TRACKS_PER_SEED,
    localparam int ID_W       = (NUM_TRACKS > 1) ? $clog2(NUM_TRACKS) : 1,
    localparam int COUNT_W    = $clog2(TRACKS_PER_SEED + 1)
) (
    input  logic               clk,
    input  logic               rst_pipe,
    input  logic               start,
    input  logic [COUNT_W-1:0] trackCount [NUM_SEEDS],
    input  logic [TRACK_W-1:0] trackIn,
    output logic [ID_W-1:0]    readAddr,
    output logic               readEnable,
    output logic               retStrobe,
    output logic [ID_W-1:0]    retId,
    output logic [TRACK_W-1:0] retTrack,
    output logic               readsFinished
);

    localparam int SEED_W = (NUM_SEEDS > 1) ? $clog2(NUM_SEEDS) : 1;
    localparam int SLOT_W = (TRACKS_PER_SEED > 1) ? $clog2(TRACKS_PER_SEED) : 1;

    logic [SEED_W-1:0] curSeed;
    logic [SLOT_W-1:0] curSlot;
    logic [SEED_W-1:0] firstSeed, nextSeed;
    logic              firstFound, nextFound;
    logic              slotLast;   // Current read is the last one of its sector
    logic              finPipe;    // One stage ahead of readsFinished
    logic              launch;

    // Priority search for nonempty sectors, lowest index wins
    always_comb begin
        firstFound = 1'b0;
        firstSeed  = '0;
        nextFound  = 1'b0;
        nextSeed   = '0;
        for (int s = NUM_SEEDS - 1; s >= 0; s--) begin
            if (trackCount[s] != '0) begin
                firstFound = 1'b1;
                firstSeed  = SEED_W'(s);
                if (s > int'(curSeed)) begin
                    nextFound = 1'b1;
                    nextSeed  = SEED_W'(s);
                end
            end
        end
    end

    assign slotLast = (COUNT_W'(curSlot) + COUNT_W'(1)) >= trackCount[curSeed];
    assign launch   = start && !readEnable && !finPipe;
    assign readAddr = ID_W'(curSeed * TRACKS_PER_SEED + curSlot);   // Global id

    always_ff @(posedge clk) begin
        if (rst_pipe) begin
            curSeed       <= '0;
            curSlot       <= '0;
            readEnable    <= 1'b0;
            retStrobe     <= 1'b0;
            finPipe       <= 1'b0;
            readsFinished <= 1'b0;
        end else begin
            retStrobe     <= readEnable;   // Memory answers one cycle later
            readsFinished <= finPipe;
            finPipe       <= (launch && !firstFound) ||
                             (readEnable && slotLast && !nextFound);
            if (launch) begin
                curSeed    <= firstSeed;
                curSlot    <= '0;
                readEnable <= firstFound;
            end else if (readEnable) begin
                if (!slotLast) begin
                    curSlot <= curSlot + 1'b1;
                end else if (nextFound) begin
                    curSeed <= nextSeed;   // Skip empty sectors
                    curSlot <= '0;
                end else begin
                    readEnable <= 1'b0;
                end
            end
        end
    end

    // Id follows the memory latency
    always_ff @(posedge clk) begin
        retId <= readAddr;
    end

    assign retTrack = trackIn;

endmodule

`default_nettype wire

// File: purgePkg.sv
`default_nettype none

package purgePkg;

    ////////////////////////////////////////////////////////////////////////////
    // Default sizes, overridden from the top level
    ////////////////////////////////////////////////////////////////////////////

    parameter int DEF_NUM_SEEDS       = 3;  // Seeding sectors
    parameter int DEF_TRACKS_PER_SEED = 4;  // Slots in each sector memory
    parameter int DEF_STUBS_PER_TRACK = 4;
    parameter int DEF_STUB_ID_W       = 6;  // Zero is reserved for "no stub"
    parameter int DEF_TRACK_W         = 32;
    parameter int DEF_MATCH_THRESHOLD = 3;  // Shared stubs that make two tracks one

    ////////////////////////////////////////////////////////////////////////////
    // State encodings
    ////////////////////////////////////////////////////////////////////////////

    // Duplicate tagger
    typedef enum logic [1:0] {
        TAG_IDLE,
        TAG_COMPARE,   // One primary per cycle
        TAG_FINISHED   // Flags final, tagDone high
    } tagState_e;

    // Output merger
    typedef enum logic [1:0] {
        MERGE_IDLE,
        MERGE_FILL,    // Collect returned tracks, wait for both finish pulses
        MERGE_DRAIN    // Emit present tracks in id order
    } mergeState_e;

endpackage

`default_nettype wire
